// ==== hw/acq_cfg.svh ====
//////////////////////////////
// Acquisition configuration
// Bus, sample and buffer sizes
//////////////////////////////

`ifndef ACQ_CFG_SVH
`define ACQ_CFG_SVH

// Raw bus word carrying one left-adjusted sample
`define ACQ_BUS_WIDTH 16
`define ACQ_ADC_WIDTH 12

// Circular buffer
`define ACQ_DEPTH      256
`define ACQ_ADDR_WIDTH 8

// Cycles from bus word to flagged sample
`define ACQ_TRIG_LATENCY 2

`endif

// ==== hw/acqPkg.sv ====
//////////////////////////////
// Acquisition types
//////////////////////////////

`include "acq_cfg.svh"

package acqPkg;

    typedef logic [`ACQ_BUS_WIDTH-1:0] busWordT;
    typedef logic signed [`ACQ_ADC_WIDTH-1:0] sampleT;
    typedef logic [`ACQ_ADDR_WIDTH-1:0] addrT;

    // One extra bit so a full buffer count fits
    typedef logic [`ACQ_ADDR_WIDTH:0] countT;

    typedef enum logic [2:0] {
        Idle,
        Fill,
        Armed,
        Acquire,
        Done
    } acqStateT;

    typedef struct packed {
        logic   valid;
        logic   trigger;
        sampleT sample;
    } flaggedSampleT;

endpackage

// ==== hw/acqIfs.sv ====
//////////////////////////////
// Memory request and RAM port
// interfaces
//////////////////////////////

`timescale 1ns/1ps

// Request side of the shared sample memory
interface memReqIf
    import acqPkg::*;
();
    logic   req;
    logic   we;
    addrT   addr;
    sampleT wdata;
    logic   gnt;
    sampleT rdata;
    logic   rvalid;

    modport requester (output req, we, addr, wdata, input gnt, rdata, rvalid);
    modport arbiter (input req, we, addr, wdata, output gnt, rdata, rvalid);
endinterface

// Single port of the sample RAM
interface ramPortIf
    import acqPkg::*;
();
    logic   en;
    logic   we;
    addrT   addr;
    sampleT wdata;
    sampleT rdata;

    modport ctrl (output en, we, addr, wdata, input rdata);
    modport mem (input en, we, addr, wdata, output rdata);
endinterface

// ==== hw/sampleTrigger.sv ====
//////////////////////////////
// Sample trigger
// Extracts samples and flags the trigger
//////////////////////////////

`timescale 1ns/1ps
`include "acq_cfg.svh"

module sampleTrigger
    import acqPkg::*;
(
    input  logic          adcClk,
    input  logic          rstN,
    input  logic          busValid,
    input  busWordT       busData,
    input  logic          eventTrigger,
    input  logic          eventEnable,
    input  logic          fallingEdge,
    input  sampleT        triggerLevel,
    input  logic          watch,
    output flaggedSampleT flagged
);
    logic   s1Valid;
    logic   s1Event;
    sampleT s1Sample;
    logic   beyond;
    logic   qualified;
    logic   flagValid;
    logic   flagTrigger;
    sampleT flagSample;

    ////////////////////////////
    // Stage 1: extraction

    always_ff @(posedge adcClk or negedge rstN) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
            s1Event <= 1'b0;
        end else begin
            s1Valid <= busValid;
            s1Event <= eventTrigger && eventEnable;
        end
    end

    // Sample sits in the top bits of the bus word
    always_ff @(posedge adcClk) begin
        s1Sample <= busData[`ACQ_BUS_WIDTH-1 -: `ACQ_ADC_WIDTH];
    end

    ////////////////////////////
    // Stage 2: level compare and flag

    assign beyond = fallingEdge ? (s1Sample < triggerLevel) : (s1Sample > triggerLevel);

    // Channel must sit on the idle side once before a level trigger counts
    always_ff @(posedge adcClk or negedge rstN) begin
        if (!rstN) begin
            qualified <= 1'b0;
        end else if (!watch) begin
            qualified <= 1'b0;
        end else if (s1Valid && !beyond) begin
            qualified <= 1'b1;
        end
    end

    always_ff @(posedge adcClk or negedge rstN) begin
        if (!rstN) begin
            flagValid   <= 1'b0;
            flagTrigger <= 1'b0;
        end else begin
            flagValid   <= s1Valid;
            flagTrigger <= s1Valid && watch && ((beyond && qualified) || s1Event);
        end
    end

    always_ff @(posedge adcClk) begin
        flagSample <= s1Sample;
    end

    assign flagged = '{valid: flagValid, trigger: flagTrigger, sample: flagSample};

endmodule

// ==== hw/acqSequencer.sv ====
//////////////////////////////
// Capture sequencer
// Fills pretrigger, waits, fills the rest
//////////////////////////////

`timescale 1ns/1ps
`include "acq_cfg.svh"

module acqSequencer
    import acqPkg::*;
(
    input  logic          adcClk,
    input  logic          rstN,
    input  logic          arm,
    input  countT         pretriggerCount,
    input  flaggedSampleT flagged,
    output logic          watch,
    output logic          acqActive,
    output logic          acqFull,
    output addrT          triggerAddr,
    output acqStateT      state,
    memReqIf.requester    memReq
);
    countT sampleCount;
    countT nextCount;
    countT postCount;
    addrT  wrAddr;
    logic  capturing;
    logic  wrDone;

    // Samples still to follow the trigger sample
    assign postCount = countT'(`ACQ_DEPTH - 1) - pretriggerCount;
    assign nextCount = sampleCount + 1'b1;

    assign capturing = (state == Fill) || (state == Armed) || (state == Acquire);

    // Write requests, granted in the same cycle
    assign memReq.req   = flagged.valid && capturing;
    assign memReq.we    = 1'b1;
    assign memReq.addr  = wrAddr;
    assign memReq.wdata = flagged.sample;
    assign wrDone       = memReq.req && memReq.gnt;

    always_ff @(posedge adcClk or negedge rstN) begin
        if (!rstN) begin
            state       <= Idle;
            watch       <= 1'b0;
            acqActive   <= 1'b0;
            acqFull     <= 1'b0;
            sampleCount <= '0;
            wrAddr      <= '0;
            triggerAddr <= '0;
        end else if (arm) begin
            acqActive   <= 1'b1;
            acqFull     <= 1'b0;
            wrAddr      <= '0;
            sampleCount <= '0;
            // No pretrigger means watching starts at once
            watch       <= (pretriggerCount == '0);
            state       <= (pretriggerCount == '0) ? Armed : Fill;
        end else begin
            // Address wraps with its own width
            if (wrDone) begin
                wrAddr <= wrAddr + 1'b1;
            end
            case (state)
                Fill: begin
                    if (wrDone) begin
                        sampleCount <= nextCount;
                        if (nextCount >= pretriggerCount) begin
                            watch <= 1'b1;
                            state <= Armed;
                        end
                    end
                end
                Armed: begin
                    if (wrDone && flagged.trigger) begin
                        triggerAddr <= wrAddr;
                        watch       <= 1'b0;
                        sampleCount <= '0;
                        if (postCount == '0) begin
                            acqActive <= 1'b0;
                            acqFull   <= 1'b1;
                            state     <= Done;
                        end else begin
                            state <= Acquire;
                        end
                    end
                end
                Acquire: begin
                    if (wrDone) begin
                        sampleCount <= nextCount;
                        if (nextCount >= postCount) begin
                            acqActive <= 1'b0;
                            acqFull   <= 1'b1;
                            state     <= Done;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== hw/memArbiter.sv ====
//////////////////////////////
// Memory arbiter
// Writes win over reads
//////////////////////////////

`timescale 1ns/1ps

module memArbiter
    import acqPkg::*;
(
    input  logic     adcClk,
    input  logic     rstN,
    memReqIf.arbiter wrPort,
    memReqIf.arbiter rdPort,
    ramPortIf.ctrl   ram
);
    logic selWrite;
    logic rdPending;
    addrT selAddr;

    assign selWrite   = wrPort.req;
    assign wrPort.gnt = wrPort.req;
    assign rdPort.gnt = rdPort.req && !wrPort.req;

    assign selAddr   = selWrite ? wrPort.addr : rdPort.addr;
    assign ram.en    = wrPort.req || rdPort.req;
    assign ram.we    = selWrite ? wrPort.we : rdPort.we;
    assign ram.addr  = selAddr;
    assign ram.wdata = selWrite ? wrPort.wdata : rdPort.wdata;

    // RAM read data lands one cycle after the grant
    always_ff @(posedge adcClk or negedge rstN) begin
        if (!rstN) begin
            rdPending <= 1'b0;
        end else begin
            rdPending <= rdPort.gnt;
        end
    end

    assign rdPort.rvalid = rdPending;
    assign rdPort.rdata  = ram.rdata;
    assign wrPort.rvalid = 1'b0;
    assign wrPort.rdata  = ram.rdata;

endmodule

// ==== hw/sampleRam.sv ====
//////////////////////////////
// Sample RAM, single port
//////////////////////////////

`timescale 1ns/1ps
`include "acq_cfg.svh"

module sampleRam
    import acqPkg::*;
(
    input logic   adcClk,
    ramPortIf.mem mem
);
    sampleT store [`ACQ_DEPTH];

    // Read data is registered, write has priority on the single port
    always_ff @(posedge adcClk) begin
        if (mem.en) begin
            if (mem.we) begin
                store[mem.addr] <= mem.wdata;
            end else begin
                mem.rdata <= store[mem.addr];
            end
        end
    end

endmodule

// ==== hw/readoutPort.sv ====
//////////////////////////////
// Host readout port
//////////////////////////////

`timescale 1ns/1ps

module readoutPort
    import acqPkg::*;
(
    input  logic       adcClk,
    input  logic       rstN,
    input  logic       readStrobe,
    input  addrT       readAddr,
    output sampleT     readData,
    output logic       readDone,
    memReqIf.requester memReq
);
    logic pending;
    addrT heldAddr;

    // Strobe requests at once, a blocked request is held
    assign memReq.req   = readStrobe || pending;
    assign memReq.we    = 1'b0;
    assign memReq.addr  = pending ? heldAddr : readAddr;
    assign memReq.wdata = '0;

    always_ff @(posedge adcClk or negedge rstN) begin
        if (!rstN) begin
            pending  <= 1'b0;
            readDone <= 1'b0;
        end else begin
            readDone <= memReq.rvalid;
            if (memReq.gnt) begin
                pending <= 1'b0;
            end else if (readStrobe) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge adcClk) begin
        if (readStrobe && !pending) begin
            heldAddr <= readAddr;
        end
        if (memReq.rvalid) begin
            readData <= memReq.rdata;
        end
    end

endmodule

// ==== hw/acqTop.sv ====
//////////////////////////////
// Acquisition top level
// Trigger, sequencer and readout
//////////////////////////////

`timescale 1ns/1ps

module acqTop
    import acqPkg::*;
(
    input  logic     adcClk,
    input  logic     rstN,
    input  logic     busValid,
    input  busWordT  busData,
    input  logic     eventTrigger,
    input  logic     eventEnable,
    input  logic     fallingEdge,
    input  sampleT   triggerLevel,
    input  countT    pretriggerCount,
    input  logic     arm,
    input  logic     readStrobe,
    input  addrT     readAddr,
    output logic     acqActive,
    output logic     acqFull,
    output addrT     triggerAddr,
    output acqStateT acqState,
    output sampleT   readData,
    output logic     readDone
);
    flaggedSampleT flagged;
    logic          watch;

    memReqIf  wrReq ();
    memReqIf  rdReq ();
    ramPortIf ramPort ();

    sampleTrigger u_sampleTrigger (
        .adcClk      (adcClk),
        .rstN        (rstN),
        .busValid    (busValid),
        .busData     (busData),
        .eventTrigger(eventTrigger),
        .eventEnable (eventEnable),
        .fallingEdge (fallingEdge),
        .triggerLevel(triggerLevel),
        .watch       (watch),
        .flagged     (flagged)
    );

    acqSequencer u_acqSequencer (
        .adcClk         (adcClk),
        .rstN           (rstN),
        .arm            (arm),
        .pretriggerCount(pretriggerCount),
        .flagged        (flagged),
        .watch          (watch),
        .acqActive      (acqActive),
        .acqFull        (acqFull),
        .triggerAddr    (triggerAddr),
        .state          (acqState),
        .memReq         (wrReq.requester)
    );

    memArbiter u_memArbiter (
        .adcClk(adcClk),
        .rstN  (rstN),
        .wrPort(wrReq.arbiter),
        .rdPort(rdReq.arbiter),
        .ram   (ramPort.ctrl)
    );

    sampleRam u_sampleRam (
        .adcClk(adcClk),
        .mem   (ramPort.mem)
    );

    readoutPort u_readoutPort (
        .adcClk    (adcClk),
        .rstN      (rstN),
        .readStrobe(readStrobe),
        .readAddr  (readAddr),
        .readData  (readData),
        .readDone  (readDone),
        .memReq    (rdReq.requester)
    );

endmodule

// ==== sim/acq_assertions.sv ====
//////////////////////////////
// Acquisition protocol checks
// Bound to the top level
//////////////////////////////

`timescale 1ns/1ps

module acqAssertions (
    input logic adcClk,
    input logic rstN,
    input logic arm,
    input logic readStrobe,
    input logic readDone,
    input logic acqActive,
    input logic acqFull
);
    int   failCount = 0;
    logic readBusy;
    int   readWait;

    // Outstanding read and its age
    always_ff @(posedge adcClk or negedge rstN) begin
        if (!rstN) begin
            readBusy <= 1'b0;
            readWait <= 0;
        end else if (readStrobe) begin
            readBusy <= 1'b1;
            readWait <= 0;
        end else if (readDone) begin
            readBusy <= 1'b0;
            readWait <= 0;
        end else if (readBusy) begin
            readWait <= readWait + 1;
        end
    end

    doneFollowsStrobe: assert property (@(posedge adcClk) disable iff (!rstN)
        readBusy |-> readWait < 64)
        else begin
            $error("readDone did not follow readStrobe");
            failCount++;
        end

    doneOnlyWhenBusy: assert property (@(posedge adcClk) disable iff (!rstN)
        readDone |-> readBusy)
        else begin
            $error("readDone without a read request");
            failCount++;
        end

    fullHoldsUntilArm: assert property (@(posedge adcClk) disable iff (!rstN)
        acqFull && !arm |=> acqFull)
        else begin
            $error("acqFull dropped without arm");
            failCount++;
        end

    armStartsCapture: assert property (@(posedge adcClk) disable iff (!rstN)
        arm |=> acqActive && !acqFull)
        else begin
            $error("arm did not start a capture");
            failCount++;
        end

    activeNotFull: assert property (@(posedge adcClk) disable iff (!rstN)
        !(acqActive && acqFull))
        else begin
            $error("acqActive and acqFull both high");
            failCount++;
        end

endmodule

bind acqTop acqAssertions u_acqAssertions (.*);

// ==== sim/acqTb.sv ====
//////////////////////////////
// Acquisition testbench
// Level and event triggers, readback against a model
//////////////////////////////

`timescale 1ns/1ps
`include "acq_cfg.svh"

module acqTb
    import acqPkg::*;
();
    localparam int StimLen    = 420;
    localparam int NumTests   = 5;
    localparam int TestCycles = StimLen * 2 + `ACQ_DEPTH * 4 + 16;
    localparam int CycleLimit = 5 * NumTests * TestCycles;

    logic     adcClk;
    logic     rstN;
    logic     busValid;
    busWordT  busData;
    logic     eventTrigger;
    logic     eventEnable;
    logic     fallingEdge;
    sampleT   triggerLevel;
    countT    pretriggerCount;
    logic     arm;
    logic     readStrobe;
    addrT     readAddr;
    logic     acqActive;
    logic     acqFull;
    addrT     triggerAddr;
    acqStateT acqState;
    sampleT   readData;
    logic     readDone;

    // Reference model
    int   stim[$];
    logic evt[$];
    int   modelMem [`ACQ_DEPTH];
    int   curLevel;
    logic curFalling;
    logic curEvent;
    int   driven;
    logic streaming;
    int   cycles = 0;

    acqTop u_acqTop (.*);

    initial begin
        adcClk = 1'b0;
        forever #20 adcClk = ~adcClk;
    end

    task automatic abortRun();
        $display("Done: errors found");
        $fatal(1);
    endtask

    // Run limit and bound assertion failures
    always @(posedge adcClk) begin
        cycles++;
        if (cycles > CycleLimit) begin
            $display("Timeout: the run took more than %0d cycles", CycleLimit);
            abortRun();
        end else if (u_acqTop.u_acqAssertions.failCount != 0) begin
            $display("A bound protocol assertion failed");
            abortRun();
        end
    end

    function automatic logic isBeyond(int value);
        return curFalling ? (value < curLevel) : (value > curLevel);
    endfunction

    //////////////////////////////
    // Stimulus and trigger model

    // Beyond stretch, idle stretch, then a ramp through the level
    function automatic void buildStim(int beyondUntil, int idleUntil, int evtAt);
        int dir;
        int r;
        dir = curFalling ? -1 : 1;
        stim.delete();
        evt.delete();
        for (int i = 0; i < StimLen; i++) begin
            if (i < beyondUntil) begin
                r = 50 + int'($urandom % 50);
            end else if (i < idleUntil) begin
                r = -50 - int'($urandom % 100);
            end else begin
                r = (i - idleUntil) * 5 - 12;
                // Plateau keeps varying so overwrites stay visible
                if (r > 600) begin
                    r = 600 + i % 97;
                end
            end
            stim.push_back(curLevel + dir * r);
            evt.push_back(i == evtAt);
        end
    endfunction

    // First sample after watch that is qualified and beyond, or carries an event
    function automatic int findTrigger(int first);
        logic qual;
        qual = 1'b0;
        for (int i = first; i < stim.size(); i++) begin
            if ((qual && isBeyond(stim[i])) || (curEvent && evt[i])) begin
                return i;
            end
            if (!isBeyond(stim[i])) begin
                qual = 1'b1;
            end
        end
        return -1;
    endfunction

    task automatic readWord(input addrT addr, output sampleT data);
        @(negedge adcClk);
        readStrobe = 1'b1;
        readAddr   = addr;
        @(negedge adcClk);
        readStrobe = 1'b0;
        while (!readDone) begin
            @(negedge adcClk);
        end
        data = readData;
    endtask

    task automatic checkWord(input addrT addr, input sampleT got, input int want);
        assert (int'(got) == want) else begin
            $display("Error: readData at addr %h is %h, expected %h", addr, got, sampleT'(want));
            abortRun();
        end
    endtask

    task automatic checkState(input acqStateT want);
        assert (acqState == want) else begin
            $display("Error: acqState is %h, expected %h", acqState, want);
            abortRun();
        end
    endtask

    // Valid words with random gaps
    task automatic streamSamples();
        int i;
        i = 0;
        while (i < stim.size()) begin
            @(negedge adcClk);
            if ($urandom % 4 == 0) begin
                busValid     = 1'b0;
                eventTrigger = 1'b0;
            end else begin
                busValid     = 1'b1;
                busData      = {sampleT'(stim[i]), {(`ACQ_BUS_WIDTH-`ACQ_ADC_WIDTH){1'b0}}};
                eventTrigger = evt[i];
                i++;
                driven = i;
            end
        end
        @(negedge adcClk);
        busValid     = 1'b0;
        eventTrigger = 1'b0;
        streaming    = 1'b0;
    endtask

    // Reads trail the write pointer by ten samples
    task automatic readDuringCapture();
        int     idx;
        sampleT got;
        while (streaming) begin
            repeat (5) @(negedge adcClk);
            idx = driven - 10;
            if (streaming && idx >= 0) begin
                readWord(addrT'(idx % `ACQ_DEPTH), got);
                checkWord(addrT'(idx % `ACQ_DEPTH), got, stim[idx]);
            end
        end
    endtask

    task automatic runTest(input int pre, input logic falling, input int level, input logic evtOn,
                           input int beyondUntil, input int idleUntil, input int evtAt);
        int     trig;
        int     total;
        sampleT got;
        addrT   prevAddr;
        curLevel        = level;
        curFalling      = falling;
        curEvent        = evtOn;
        fallingEdge     = falling;
        eventEnable     = evtOn;
        triggerLevel    = sampleT'(level);
        pretriggerCount = countT'(pre);
        buildStim(beyondUntil, idleUntil, evtAt);
        trig  = findTrigger(pre);
        // Trigger sample plus the samples that follow it
        total = trig + `ACQ_DEPTH - pre;
        if (trig < 0 || total + 6 > stim.size()) begin
            $display("Stimulus never fills the buffer");
            abortRun();
        end
        while (stim.size() > total + 6) begin
            void'(stim.pop_back());
        end

        repeat (3) @(negedge adcClk);
        arm = 1'b1;
        @(negedge adcClk);
        arm       = 1'b0;
        checkState((pre == 0) ? Armed : Fill);
        driven    = 0;
        streaming = 1'b1;
        fork
            streamSamples();
            readDuringCapture();
        join
        while (!acqFull) begin
            @(negedge adcClk);
        end
        checkState(Done);

        for (int i = 0; i < total; i++) begin
            modelMem[i % `ACQ_DEPTH] = stim[i];
        end
        for (int a = 0; a < `ACQ_DEPTH; a++) begin
            readWord(addrT'(a), got);
            checkWord(addrT'(a), got, modelMem[a]);
        end

        // Level rule at the reported trigger address
        prevAddr = triggerAddr - 1'b1;
        assert (evtOn || isBeyond(modelMem[triggerAddr])) else begin
            $display("Trigger word at %h is not beyond the level", triggerAddr);
            abortRun();
        end
        assert (!isBeyond(modelMem[prevAddr])) else begin
            $display("Word before the trigger at %h is already beyond the level", prevAddr);
            abortRun();
        end

        assert (triggerAddr == addrT'(trig % `ACQ_DEPTH)) else begin
            $display("Error: triggerAddr is %h, expected %h", triggerAddr,
                     addrT'(trig % `ACQ_DEPTH));
            abortRun();
        end
    endtask

    //////////////////////////////
    // Main sequence

    initial begin
        void'($urandom(32'hb4ec_9b7a));
        rstN            = 1'b0;
        busValid        = 1'b0;
        busData         = '0;
        eventTrigger    = 1'b0;
        eventEnable     = 1'b0;
        fallingEdge     = 1'b0;
        triggerLevel    = '0;
        pretriggerCount = '0;
        arm             = 1'b0;
        readStrobe      = 1'b0;
        readAddr        = '0;
        streaming       = 1'b0;
        driven          = 0;
        repeat (8) @(negedge adcClk);
        rstN = 1'b1;
        checkState(Idle);

        // Rising ramp after an idle stretch
        runTest(20, 1'b0, 200, 1'b0, 0, 80, -1);
        // Falling ramp
        runTest(30, 1'b1, -100, 1'b0, 0, 60, -1);
        // Armed while the input already sits above the level
        runTest(10, 1'b0, 300, 1'b0, 70, 90, -1);
        // Long pretrigger, write address wraps before the trigger
        runTest(200, 1'b0, 0, 1'b0, 0, 300, -1);
        // Event strobe with the level never crossed
        runTest(40, 1'b0, 1000, 1'b1, 0, StimLen, 150);

        repeat (4) @(negedge adcClk);
        if (u_acqTop.u_acqAssertions.failCount == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("A bound protocol assertion failed");
            abortRun();
        end
    end

endmodule

// ==== build.f ====
+incdir+hw
hw/acqPkg.sv
hw/acqIfs.sv
hw/sampleTrigger.sv
hw/acqSequencer.sv
hw/memArbiter.sv
hw/sampleRam.sv
hw/readoutPort.sv
hw/acqTop.sv
sim/acq_assertions.sv
sim/acqTb.sv

// ==== Makefile ====
# Verilator build and run of the acquisition testbench

TOP = acqTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
